// ==== run_sim.sh ====
#!/bin/sh
# build and run the uP bridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module up_bridge_tb \
   -o up_bridge_sim
out=$(./obj_dir/up_bridge_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "All checks passed"; then
   echo "simulation PASSED"
else
   echo "simulation FAILED"
   exit 1
fi

// ==== source/register_bank.sv ====
/*
 Internal bus slave with 8 registers. Register 0 reads BANK_ID and refuses
 writes. Addresses 8 to 15 are never answered. The answer comes a fixed
 BANK_LATENCY cycles after the strobe and echoes the register contents.
*/
`default_nettype none
`include "up_bridge_defines.svh"

module register_bank (
   input  wire logic clk,
   input  wire logic reset,
   input  wire up_bridge_pkg::reg_num_t bus_reg_address,
   input  wire logic bus_write,
   input  wire up_bridge_pkg::word_t bus_data_out,
   input  wire logic bus_register_address_valid,
   input  wire logic bus_handshake_1,
   output up_bridge_pkg::word_t bus_data_in,
   output logic bus_handshake_2,
   output logic bus_nfault
);

   import up_bridge_pkg::*;

   localparam int IDX_W = $clog2(`NUM_REGS);

   word_t regs [1:`NUM_REGS-1];   // reg 0 is the constant id
   word_t read_word;
   logic [IDX_W-1:0] reg_idx;
   logic [3:0] delay;             // cycles until answer
   logic busy, implemented, start, answer, refused;

   assign reg_idx     = bus_reg_address[IDX_W-1:0];
   assign implemented = (bus_reg_address < reg_num_t'(`NUM_REGS));
   // no restart while the answer pulse is still up
   assign start   = bus_handshake_1 && bus_register_address_valid && implemented
                    && !busy && !bus_handshake_2;
   assign answer  = busy && (delay == '0);
   assign refused = bus_write && (reg_idx == '0);

   always_comb begin
      if (reg_idx == '0) begin
         read_word = `BANK_ID;
      end else begin
         read_word = regs[reg_idx];
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         busy            <= 1'b0;
         delay           <= '0;
         bus_handshake_2 <= 1'b0;
         bus_nfault      <= 1'b1;
         for (int i = 1; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         bus_handshake_2 <= answer;   // one cycle pulse
         if (start) begin
            busy       <= 1'b1;
            delay      <= 4'(`BANK_LATENCY - 1);
            bus_nfault <= 1'b1;       // accepted, old fault cleared
         end else if (answer) begin
            busy <= 1'b0;
            if (refused) begin
               bus_nfault <= 1'b0;
            end else if (bus_write) begin
               regs[reg_idx] <= bus_data_out;
            end
         end else if (busy) begin
            delay <= delay - 1'b1;
         end
      end
   end

   // reply word, address and data held by the bridge until answer
   always_ff @(posedge clk) begin
      if (answer) begin
         bus_data_in <= (bus_write && !refused) ? bus_data_out : read_word;
      end
   end

   a_hs2_pulse: assert property (@(posedge clk) disable iff (!reset)
      bus_handshake_2 |=> !bus_handshake_2);

endmodule

`default_nettype wire

// ==== source/up_bridge.sv ====
/*
 Datapath of the uP bridge: 6-byte command in, 5-byte reply out.
 uP pins must already be synchronous to clk. The data pin is split into
 in, out and drive enable; the tristate lives in the pad ring.
*/
`default_nettype none
`include "up_bridge_defines.svh"

module up_bridge (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic up_start,
   input  wire logic up_handshake_1,
   input  wire logic up_rw,
   input  wire up_bridge_pkg::byte_t up_data_in,
   input  wire up_bridge_pkg::word_t bus_data_in,
   input  wire logic bus_handshake_2,
   input  wire logic bus_nfault,
   output logic up_ack,
   output logic up_handshake_2,
   output up_bridge_pkg::byte_t up_data_out,
   output logic up_data_oe,
   output logic up_nfault,
   output up_bridge_pkg::reg_num_t bus_reg_address,
   output logic bus_write,
   output up_bridge_pkg::word_t bus_data_out,
   output logic bus_register_address_valid,
   output logic bus_handshake_1
);

   import up_bridge_pkg::*;

   logic counter_zero, timeout_zero, reg_in_range, cmd_write, cmd_reset;
   logic set_cmd_count, set_reply_count, capture_byte, present_byte;
   logic load_reply_word, clear_packet, set_timeout, dec_timeout;
   byte_t load_status;

   byte_t    cmd_pkt [`UP_CMD_BYTES];     // command packet as received
   byte_t    reply_pkt [`UP_REPLY_BYTES]; // status then data lsb first
   byte_t    byte_count;                  // bytes left in current packet
   timeout_t timeout_count;
   logic [2:0] cmd_idx, reply_idx;

   up_bridge_fsm fsm_i (
      .clk                        (clk),
      .reset                      (reset),
      .up_start                   (up_start),
      .up_handshake_1             (up_handshake_1),
      .bus_handshake_2            (bus_handshake_2),
      .bus_nfault                 (bus_nfault),
      .counter_zero               (counter_zero),
      .timeout_zero               (timeout_zero),
      .reg_in_range               (reg_in_range),
      .cmd_write                  (cmd_write),
      .cmd_reset                  (cmd_reset),
      .up_ack                     (up_ack),
      .up_handshake_2             (up_handshake_2),
      .up_data_oe                 (up_data_oe),
      .bus_handshake_1            (bus_handshake_1),
      .bus_register_address_valid (bus_register_address_valid),
      .set_cmd_count              (set_cmd_count),
      .set_reply_count            (set_reply_count),
      .capture_byte               (capture_byte),
      .present_byte               (present_byte),
      .load_reply_word            (load_reply_word),
      .load_status                (load_status),
      .clear_packet               (clear_packet),
      .set_timeout                (set_timeout),
      .dec_timeout                (dec_timeout)
   );

   // counter runs down, so position = length - remaining
   assign cmd_idx      = 3'(byte_t'(`UP_CMD_BYTES) - byte_count);
   assign reply_idx    = 3'(byte_t'(`UP_REPLY_BYTES) - byte_count);
   assign counter_zero = (byte_count == '0);
   assign timeout_zero = (timeout_count == '0);

   // byte counter and command buffer
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         byte_count <= '0;
         for (int i = 0; i < `UP_CMD_BYTES; i++) begin
            cmd_pkt[i] <= '0;
         end
      end else if (set_cmd_count) begin
         byte_count <= byte_t'(`UP_CMD_BYTES);
      end else if (set_reply_count) begin
         byte_count <= byte_t'(`UP_REPLY_BYTES);
      end else if (capture_byte) begin
         if (up_rw) begin
            cmd_pkt[cmd_idx] <= up_data_in;   // uP writing to bridge
         end
         byte_count <= byte_count - 1'b1;
      end else if (present_byte) begin
         byte_count <= byte_count - 1'b1;
      end
   end

   // reply buffer and output byte
   always_ff @(posedge clk) begin
      if (clear_packet) begin
         for (int i = 1; i < `UP_REPLY_BYTES; i++) begin
            reply_pkt[i] <= '0;
         end
      end
      if (load_reply_word) begin
         reply_pkt[1] <= bus_data_in[7:0];
         reply_pkt[2] <= bus_data_in[15:8];
         reply_pkt[3] <= bus_data_in[23:16];
         reply_pkt[4] <= bus_data_in[31:24];
      end
      if (set_reply_count) begin
         reply_pkt[0] <= load_status;
      end
      if (present_byte) begin
         up_data_out <= reply_pkt[reply_idx];   // held while handshake_2 high
      end
   end

   // bus timeout
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         timeout_count <= '0;
      end else if (set_timeout) begin
         timeout_count <= timeout_t'(`TIMEOUT_COUNT);
      end else if (dec_timeout && !timeout_zero) begin
         timeout_count <= timeout_count - 1'b1;
      end
   end

   assign cmd_write    = cmd_pkt[`PKT_CMD][`CMD_WRITE_BIT];
   assign cmd_reset    = cmd_pkt[`PKT_CMD][`CMD_RESET_BIT];
   assign reg_in_range = (cmd_pkt[`PKT_REG] < byte_t'(`REG_SPACE));

   assign bus_reg_address = cmd_pkt[`PKT_REG];
   assign bus_write       = cmd_write;
   assign bus_data_out    = {cmd_pkt[`PKT_DATA+3], cmd_pkt[`PKT_DATA+2],
                             cmd_pkt[`PKT_DATA+1], cmd_pkt[`PKT_DATA]};
   assign up_nfault       = bus_nfault;

   a_count_bounded: assert property (@(posedge clk) disable iff (!reset)
      byte_count <= byte_t'(`UP_CMD_BYTES));

endmodule

`default_nettype wire

// ==== source/up_bridge_defines.svh ====
/*
 Constants shared by the bridge, the register bank and the testbench.
 Status codes are one-hot so they can be told apart on a scope.
*/
`ifndef UP_BRIDGE_DEFINES_SVH
`define UP_BRIDGE_DEFINES_SVH

// packet lengths in bytes
`define UP_CMD_BYTES       6
`define UP_REPLY_BYTES     5

// byte positions in the command packet, data is lsb first
`define PKT_CMD            0
`define PKT_REG            1
`define PKT_DATA           2

// command byte bits
`define CMD_WRITE_BIT      0
`define CMD_RESET_BIT      7

// register bank layout and timing
`define REG_SPACE          16
`define NUM_REGS           8
`define BANK_ID            32'hB41F_0001
`define BANK_LATENCY       2
`define TIMEOUT_COUNT      64

// reply status codes
`define STATUS_OK          8'h00
`define STATUS_BAD_REG     8'h01
`define STATUS_TIMEOUT     8'h02
`define STATUS_WRITE_FAULT 8'h04
`define STATUS_RESET_DONE  8'h80

`endif

// ==== source/up_bridge_fsm.sv ====
/*
 Sequencer for the uP bridge. Byte handshakes wait forever on the uP;
 only the bus request is bounded by the timeout counter.
 Soft reset and bad register numbers skip the bus cycle.
*/
`default_nettype none
`include "up_bridge_defines.svh"

module up_bridge_fsm (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic up_start,
   input  wire logic up_handshake_1,
   input  wire logic bus_handshake_2,
   input  wire logic bus_nfault,
   input  wire logic counter_zero,
   input  wire logic timeout_zero,
   input  wire logic reg_in_range,
   input  wire logic cmd_write,
   input  wire logic cmd_reset,
   output logic up_ack,
   output logic up_handshake_2,
   output logic up_data_oe,
   output logic bus_handshake_1,
   output logic bus_register_address_valid,
   output logic set_cmd_count,
   output logic set_reply_count,
   output logic capture_byte,
   output logic present_byte,
   output logic load_reply_word,
   output up_bridge_pkg::byte_t load_status,
   output logic clear_packet,
   output logic set_timeout,
   output logic dec_timeout
);

   import up_bridge_pkg::*;

   bridge_state_t state, next_state;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= ST_IDLE;
      end else begin
         state <= next_state;
      end
   end

   // moore outputs, all low in idle
   assign up_ack          = (state == ST_DONE);
   assign up_handshake_2  = (state == ST_CMD_ACK) || (state == ST_REPLY_ACK);
   assign up_data_oe      = (state == ST_REPLY_ACK);   // byte only driven with handshake_2
   assign bus_handshake_1 = (state == ST_BUS_REQ);
   assign bus_register_address_valid = (state == ST_BUS_REQ) && reg_in_range;

   always_comb begin
      next_state      = state;
      set_cmd_count   = 1'b0;
      set_reply_count = 1'b0;
      capture_byte    = 1'b0;
      present_byte    = 1'b0;
      load_reply_word = 1'b0;
      load_status     = `STATUS_OK;   // latched with set_reply_count
      clear_packet    = 1'b0;
      set_timeout     = 1'b0;
      dec_timeout     = 1'b0;
      case (state)
         ST_IDLE: begin
            if (up_start) begin
               set_cmd_count = 1'b1;
               next_state    = ST_CMD_WAIT;
            end
         end
         ST_CMD_WAIT: begin
            if (up_handshake_1) begin
               capture_byte = 1'b1;   // same edge as handshake_2 rising
               next_state   = ST_CMD_ACK;
            end
         end
         ST_CMD_ACK: begin
            if (!up_handshake_1) begin
               next_state = counter_zero ? ST_DECODE : ST_CMD_WAIT;
            end
         end
         ST_DECODE: begin
            clear_packet = 1'b1;   // zero reply data before any load
            if (cmd_reset) begin
               load_status     = `STATUS_RESET_DONE;
               set_reply_count = 1'b1;
               next_state      = ST_REPLY_WAIT;
            end else if (!reg_in_range) begin
               load_status     = `STATUS_BAD_REG;
               set_reply_count = 1'b1;
               next_state      = ST_REPLY_WAIT;
            end else begin
               set_timeout = 1'b1;
               next_state  = ST_BUS_REQ;
            end
         end
         ST_BUS_REQ: begin
            dec_timeout = 1'b1;
            if (bus_handshake_2) begin
               load_reply_word = 1'b1;
               set_reply_count = 1'b1;
               // only a write can be refused by the bank
               if (cmd_write && !bus_nfault) begin
                  load_status = `STATUS_WRITE_FAULT;
               end
               next_state = ST_REPLY_WAIT;
            end else if (timeout_zero) begin
               load_status     = `STATUS_TIMEOUT;   // data stays zero
               set_reply_count = 1'b1;
               next_state      = ST_REPLY_WAIT;
            end
         end
         ST_REPLY_WAIT: begin
            if (up_handshake_1) begin
               present_byte = 1'b1;   // load up_data_out with handshake_2
               next_state   = ST_REPLY_ACK;
            end
         end
         ST_REPLY_ACK: begin
            if (!up_handshake_1) begin
               next_state = counter_zero ? ST_DONE : ST_REPLY_WAIT;
            end
         end
         ST_DONE: begin
            if (!up_start) begin
               next_state = ST_IDLE;
            end
         end
         default: next_state = ST_IDLE;
      endcase
   end

   // uP side handshake order
   a_hs2_follows_hs1: assert property (@(posedge clk) disable iff (!reset)
      $rose(up_handshake_2) |-> $past(up_handshake_1));

   // no bus strobe unless the range check passed
   a_bus_strobe_valid: assert property (@(posedge clk) disable iff (!reset)
      bus_handshake_1 |-> bus_register_address_valid);

endmodule

`default_nettype wire

// ==== source/up_bridge_pkg.sv ====
/*
 Types for the microprocessor bridge and its register bank.
*/
`default_nettype none

package up_bridge_pkg;

   typedef logic [7:0]  byte_t;      // uP port byte, packet byte
   typedef logic [31:0] word_t;      // internal bus word
   typedef logic [7:0]  reg_num_t;   // register number as sent in the packet
   typedef logic [15:0] timeout_t;   // bus timeout count

   typedef enum logic [3:0] {
      ST_IDLE,        // wait for up_start
      ST_CMD_WAIT,    // command byte, wait for handshake_1 high
      ST_CMD_ACK,     // command byte, handshake_2 up, wait for handshake_1 low
      ST_DECODE,      // pick bus cycle or direct status
      ST_BUS_REQ,     // bus handshake_1 held, wait for answer or timeout
      ST_REPLY_WAIT,  // reply byte, wait for handshake_1 high
      ST_REPLY_ACK,   // reply byte driven, wait for handshake_1 low
      ST_DONE         // up_ack held until up_start falls
   } bridge_state_t;

endpackage

`default_nettype wire

// ==== source/up_bridge_top.sv ====
/*
 uP bridge with its register bank. uP pins assumed synchronous to clk.
*/
`default_nettype none

module up_bridge_top (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic up_start,
   input  wire logic up_handshake_1,
   input  wire logic up_rw,
   input  wire up_bridge_pkg::byte_t up_data_in,
   output logic up_ack,
   output logic up_handshake_2,
   output up_bridge_pkg::byte_t up_data_out,
   output logic up_data_oe,
   output logic up_nfault
);

   import up_bridge_pkg::*;

   reg_num_t bus_reg_address;
   word_t    bus_data_out, bus_data_in;
   logic     bus_write, bus_register_address_valid;
   logic     bus_handshake_1, bus_handshake_2, bus_nfault;

   up_bridge bridge_i (
      .clk                        (clk),
      .reset                      (reset),
      .up_start                   (up_start),
      .up_handshake_1             (up_handshake_1),
      .up_rw                      (up_rw),
      .up_data_in                 (up_data_in),
      .bus_data_in                (bus_data_in),
      .bus_handshake_2            (bus_handshake_2),
      .bus_nfault                 (bus_nfault),
      .up_ack                     (up_ack),
      .up_handshake_2             (up_handshake_2),
      .up_data_out                (up_data_out),
      .up_data_oe                 (up_data_oe),
      .up_nfault                  (up_nfault),
      .bus_reg_address            (bus_reg_address),
      .bus_write                  (bus_write),
      .bus_data_out               (bus_data_out),
      .bus_register_address_valid (bus_register_address_valid),
      .bus_handshake_1            (bus_handshake_1)
   );

   register_bank bank_i (
      .clk                        (clk),
      .reset                      (reset),
      .bus_reg_address            (bus_reg_address),
      .bus_write                  (bus_write),
      .bus_data_out               (bus_data_out),
      .bus_register_address_valid (bus_register_address_valid),
      .bus_handshake_1            (bus_handshake_1),
      .bus_data_in                (bus_data_in),
      .bus_handshake_2            (bus_handshake_2),
      .bus_nfault                 (bus_nfault)
   );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/up_bridge_pkg.sv
source/up_bridge_fsm.sv
source/up_bridge.sv
source/register_bank.sv
source/up_bridge_top.sv
test/up_bridge_tb.sv

// ==== test/up_bridge_tb.sv ====
/*
 Testbench for the uP bridge with its register bank. A shadow copy of the
 registers feeds the reference model. Replies are captured off the uP pins
 and compared when up_ack rises. Every wait is bounded.
*/
`default_nettype none
`include "up_bridge_defines.svh"

module up_bridge_tb;

   import up_bridge_pkg::*;

   localparam int HS_LIMIT   = 200;   // cycles, covers a full bus timeout
   localparam int DONE_LIMIT = 20;

   logic  clk = 1'b0;
   logic  reset, up_start, up_handshake_1, up_rw;
   byte_t up_data_in, up_data_out;
   logic  up_ack, up_handshake_2, up_data_oe, up_nfault;

   word_t  shadow_regs [1:`NUM_REGS-1];   // expected bank contents
   logic   shadow_nfault;
   integer seed;
   int     rnd, issued_count, checked_count;

   // expected replies, in issue order
   string exp_name_q [$];
   byte_t exp_status_q [$];
   word_t exp_word_q [$];
   logic  exp_nfault_q [$];

   byte_t reply_bytes [`UP_REPLY_BYTES];
   int    reply_pos;
   logic  hs2_prev, ack_prev;

   up_bridge_top dut_i (
      .clk            (clk),
      .reset          (reset),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_rw          (up_rw),
      .up_data_in     (up_data_in),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .up_data_out    (up_data_out),
      .up_data_oe     (up_data_oe),
      .up_nfault      (up_nfault)
   );

   always #10 clk = ~clk;   // 20 unit period

   task automatic stop_on_failure();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out waiting for %s", what);
      stop_on_failure();
   endtask

   task automatic check_byte(input string name, input byte_t exp, input byte_t act);
      if (exp !== act) begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         stop_on_failure();
      end
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         stop_on_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAIL %s: expected %b, actual %b", name, exp, act);
         stop_on_failure();
      end
   endtask

   // reply = {data word, status}
   function automatic logic [39:0] expected_reply(input byte_t cmd, input reg_num_t reg_num,
                                                  input word_t data);
      byte_t status;
      word_t data_word;
      status    = `STATUS_OK;
      data_word = '0;
      if (cmd[`CMD_RESET_BIT]) begin
         status = `STATUS_RESET_DONE;   // no bus cycle, data zero
      end else if (reg_num >= `REG_SPACE) begin
         status = `STATUS_BAD_REG;
      end else if (reg_num >= `NUM_REGS) begin
         status = `STATUS_TIMEOUT;      // hole, bank stays silent
      end else if (reg_num == 0) begin
         data_word = `BANK_ID;          // id read, refused write echoes it too
         if (cmd[`CMD_WRITE_BIT]) begin
            status = `STATUS_WRITE_FAULT;
         end
      end else if (cmd[`CMD_WRITE_BIT]) begin
         data_word = data;              // write echoes its own data
      end else begin
         data_word = shadow_regs[reg_num[2:0]];
      end
      return {data_word, status};
   endfunction

   task automatic update_shadow(input byte_t cmd, input reg_num_t reg_num, input word_t data);
      if (!cmd[`CMD_RESET_BIT] && reg_num < `NUM_REGS) begin   // bank accepted it
         shadow_nfault = !(cmd[`CMD_WRITE_BIT] && reg_num == 0);
         if (cmd[`CMD_WRITE_BIT] && reg_num != 0) begin
            shadow_regs[reg_num[2:0]] = data;
         end
      end
   endtask

   task automatic wait_hs2(input logic level, input string what);
      int cycles;
      cycles = 0;
      while (up_handshake_2 !== level && cycles < HS_LIMIT) begin
         @(posedge clk);
         #2;
         cycles++;
      end
      if (up_handshake_2 !== level) begin
         report_timeout(what);
      end
   endtask

   task automatic wait_ack(input logic level, input string what);
      int cycles;
      cycles = 0;
      while (up_ack !== level && cycles < HS_LIMIT) begin
         @(posedge clk);
         #2;
         cycles++;
      end
      if (up_ack !== level) begin
         report_timeout(what);
      end
   endtask

   // one four-phase byte exchange on the uP port
   task automatic byte_exchange(input string name);
      up_handshake_1 = 1'b1;
      wait_hs2(1'b1, {name, ": handshake_2 rise"});
      up_handshake_1 = 1'b0;
      wait_hs2(1'b0, {name, ": handshake_2 fall"});
   endtask

   task automatic run_transaction(input string name, input byte_t cmd,
                                  input reg_num_t reg_num, input word_t data);
      byte_t       pkt [`UP_CMD_BYTES];
      logic [39:0] exp;
      pkt[`PKT_CMD] = cmd;
      pkt[`PKT_REG] = reg_num;
      for (int i = 0; i < 4; i++) begin
         pkt[`PKT_DATA+i] = data[8*i +: 8];   // lsb first
      end
      exp = expected_reply(cmd, reg_num, data);
      update_shadow(cmd, reg_num, data);
      exp_name_q.push_back(name);
      exp_status_q.push_back(exp[7:0]);
      exp_word_q.push_back(exp[39:8]);
      exp_nfault_q.push_back(shadow_nfault);
      issued_count++;
      up_start = 1'b1;
      up_rw    = 1'b1;
      for (int i = 0; i < `UP_CMD_BYTES; i++) begin
         up_data_in = pkt[i];
         byte_exchange(name);
      end
      up_rw = 1'b0;   // reply bytes
      for (int i = 0; i < `UP_REPLY_BYTES; i++) begin
         byte_exchange(name);
      end
      wait_ack(1'b1, {name, ": up_ack rise"});
      up_start = 1'b0;
      wait_ack(1'b0, {name, ": up_ack fall"});
   endtask

   // capture reply bytes mid cycle, compare on up_ack rising
   always @(negedge clk) begin
      if (reset) begin
         // data pin driven only while a reply byte is handed over
         check_bit("up_data_oe", up_handshake_2 && !up_rw, up_data_oe);
         if (up_handshake_2 && up_data_oe && !hs2_prev && reply_pos < `UP_REPLY_BYTES) begin
            reply_bytes[reply_pos] = up_data_out;
            reply_pos++;
         end
         if (up_ack && !ack_prev) begin
            if (exp_name_q.size() == 0) begin
               $display("up_ack arrived with no transaction outstanding");
               stop_on_failure();
            end
            if (reply_pos != `UP_REPLY_BYTES) begin
               $display("%s: reply had %0d bytes instead of %0d", exp_name_q[0], reply_pos,
                        `UP_REPLY_BYTES);
               stop_on_failure();
            end
            check_byte({exp_name_q[0], " status"}, exp_status_q.pop_front(), reply_bytes[0]);
            check_word({exp_name_q[0], " data"}, exp_word_q.pop_front(),
                       {reply_bytes[4], reply_bytes[3], reply_bytes[2], reply_bytes[1]});
            check_bit({exp_name_q[0], " up_nfault"}, exp_nfault_q.pop_front(), up_nfault);
            void'(exp_name_q.pop_front());
            reply_pos = 0;
            checked_count++;
         end
         hs2_prev = up_handshake_2;
         ack_prev = up_ack;
      end
   end

   initial begin : stimulus
      reg_num_t r;
      word_t    d;
      int       cycles;
      reset          = 1'b0;
      up_start       = 1'b0;
      up_handshake_1 = 1'b0;
      up_rw          = 1'b0;
      up_data_in     = '0;
      seed           = 32'h655c;
      shadow_nfault  = 1'b1;
      reply_pos      = 0;
      hs2_prev       = 1'b0;
      ack_prev       = 1'b0;
      issued_count   = 0;
      checked_count  = 0;
      for (int i = 1; i < `NUM_REGS; i++) begin
         shadow_regs[i] = '0;
      end
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b1;
      @(posedge clk);
      #2;
      check_bit("up_nfault after reset", 1'b1, up_nfault);

      // random writes, each followed by a random read
      for (int i = 0; i < 8; i++) begin
         rnd = $random(seed);
         r   = reg_num_t'(1 + (rnd[15:0] % 7));
         d   = $random(seed);
         run_transaction($sformatf("write r%0d", r), 8'h01, r, d);
         rnd = $random(seed);
         r   = reg_num_t'(1 + (rnd[15:0] % 7));
         run_transaction($sformatf("read r%0d", r), 8'h00, r, $random(seed));
      end
      run_transaction("read id", 8'h00, 8'd0, '0);

      // out of range register numbers
      rnd = $random(seed);
      run_transaction("bad reg random", 8'h00, reg_num_t'(16 + (rnd[15:0] % 240)), '0);
      run_transaction("bad reg ff", 8'h01, 8'hff, $random(seed));

      // hole, then a normal transaction
      rnd = $random(seed);
      run_transaction("hole", 8'h00, reg_num_t'(8 + (rnd[15:0] % 8)), '0);
      run_transaction("read after hole", 8'h00, 8'd5, '0);

      // refused write, nfault stays low until the bank accepts again
      run_transaction("write id", 8'h01, 8'd0, $random(seed));
      run_transaction("bad reg after fault", 8'h00, 8'd40, '0);
      run_transaction("read id after fault", 8'h00, 8'd0, '0);

      // soft reset leaves the bank alone, even with the write bit set
      run_transaction("soft reset", 8'h80, 8'd3, $random(seed));
      run_transaction("soft reset write", 8'h81, 8'd2, $random(seed));
      for (int i = 1; i < `NUM_REGS; i++) begin
         run_transaction($sformatf("readback r%0d", i), 8'h00, reg_num_t'(i), '0);
      end

      cycles = 0;
      while (checked_count != issued_count && cycles < DONE_LIMIT) begin
         @(posedge clk);
         #2;
         cycles++;
      end
      if (checked_count != issued_count) begin
         report_timeout("the last replies to be compared");
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

`default_nettype wire
